//--- cache_sys.f
hdl/cache_pkg.sv
hdl/load_align.sv
hdl/cache_store.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
dv/mem_model.sv
dv/tb_cache.sv

//--- dv/mem_model.sv
`timescale 1ns/1ps

module mem_model (
    input  logic               clk,
    input  logic               reset,
    input  cache_pkg::wb_req_t req,
    output cache_pkg::wb_rsp_t rsp,
    output int                 read_count
);

    logic [7:0]  mem [65536];
    logic [31:0] lfsr;
    logic [31:0] s1;
    logic [31:0] s2;
    logic [1:0]  wait_cnt;
    logic        busy;
    logic [15:0] a;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    assign s1 = lfsr_next(lfsr);
    assign s2 = lfsr_next(s1);
    assign a  = {req.adr[15:2], 2'b00};

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[16'(i)] = 8'(i * 7 + 3) ^ 8'(i >> 8);
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            rsp        <= '0;
            busy       <= 1'b0;
            wait_cnt   <= 2'd0;
            lfsr       <= 32'h7b9e;
            read_count <= 0;
        end else begin
            rsp.ack <= 1'b0;
            if (!busy && req.cyc && req.stb && !rsp.ack) begin
                // Between 0 and 3 wait states per transfer
                wait_cnt <= {s1[0], s2[0]};
                lfsr     <= s2;
                busy     <= 1'b1;
            end else if (busy && wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else if (busy) begin
                busy    <= 1'b0;
                rsp.ack <= 1'b1;
                if (req.we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (req.sel[b]) begin
                            mem[a + 16'(b)] <= req.dat_w[8*b +: 8];
                        end
                    end
                end else begin
                    rsp.dat_r  <= {mem[a + 16'd3], mem[a + 16'd2], mem[a + 16'd1], mem[a]};
                    read_count <= read_count + 1;
                end
            end
        end
    end

endmodule

//--- dv/tb_cache.sv
`timescale 1ns/1ps

module tb_cache;

    localparam int N_TRANS = 328;

    logic                clk = 1'b0;
    logic                reset;
    cache_pkg::cpu_req_t cpu_req;
    cache_pkg::cpu_rsp_t cpu_rsp;
    cache_pkg::wb_req_t  mem_req;
    cache_pkg::wb_rsp_t  mem_rsp;
    int                  read_count;
    int                  write_count = 0;
    int                  errors = 0;
    int                  checks = 0;
    logic [31:0]         rng = 32'h7b9e;
    logic [7:0]          ref_mem [65536];
    logic [31:0]         rd_addrs [$];
    logic                exp_load = 1'b0;
    logic [31:0]         exp_data;
    logic [3:0]          exp_sel;
    logic [31:0]         exp_wdat;
    logic [31:0]         exp_wadr;
    logic [31:0]         lane_mask;

    cache_top #(.NUM_LINES(64), .LINE_WORDS(8)) cache_top_i (.*);

    mem_model mem_model_i (.clk, .reset, .req(mem_req), .rsp(mem_rsp), .read_count);

    always #4 clk = ~clk;

    assign lane_mask = {{8{exp_sel[3]}}, {8{exp_sel[2]}}, {8{exp_sel[1]}}, {8{exp_sel[0]}}};

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic get_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            rng = lfsr_next(rng);
            v   = {v[30:0], rng[0]};
        end
    endtask

    // Load result from the byte image of memory
    function automatic logic [31:0] ref_load(input cache_pkg::lsu_op_e op,
                                             input logic [15:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = ref_mem[a];
        h = {ref_mem[a + 16'd1], ref_mem[a]};
        case (op)
            cache_pkg::op_lb:  return {{24{b[7]}}, b};
            cache_pkg::op_lbu: return {24'b0, b};
            cache_pkg::op_lh:  return {{16{h[15]}}, h};
            cache_pkg::op_lhu: return {16'b0, h};
            default:           return {ref_mem[a + 16'd3], ref_mem[a + 16'd2], h};
        endcase
    endfunction

    task automatic run_op(input cache_pkg::lsu_op_e op, input logic [15:0] a,
                          input logic [31:0] d, input int exp_reads);
        int          reads0;
        int          writes0;
        logic        store;
        logic [31:0] exp_adr;
        reads0   = read_count;
        writes0  = write_count;
        store    = op inside {cache_pkg::op_sb, cache_pkg::op_sh, cache_pkg::op_sw};
        rd_addrs.delete();
        exp_load = !store;
        exp_data = ref_load(op, a);
        exp_sel  = op == cache_pkg::op_sb ? 4'b0001 << a[1:0] :
                   op == cache_pkg::op_sh ? (a[1] ? 4'b1100 : 4'b0011) : 4'b1111;
        exp_wdat = d << (8 * a[1:0]);
        exp_wadr = {16'b0, a[15:2], 2'b00};
        if (store) begin
            for (int b = 0; b < 4; b++) begin
                if (exp_sel[b]) begin
                    ref_mem[{a[15:2], 2'(b)}] = exp_wdat[8*b +: 8];
                end
            end
        end
        @(posedge clk);
        #1;
        cpu_req = '{cyc: 1'b1, stb: 1'b1, op: op, adr: {16'b0, a}, dat_w: d};
        do @(negedge clk); while (!cpu_rsp.ack);
        @(posedge clk);
        #1;
        cpu_req.cyc = 1'b0;
        cpu_req.stb = 1'b0;
        checks++;
        if (exp_reads >= 0 && read_count - reads0 != exp_reads) begin
            errors++;
            $display("** Error read_count: got %h, expected %h (adr %h)",
                     read_count - reads0, exp_reads, a);
        end
        // Refill walks the line in ascending word order
        if (exp_reads == 8) begin
            foreach (rd_addrs[i]) begin
                exp_adr = {16'b0, a[15:5], 5'b0} + 32'(4 * i);
                checks++;
                if (rd_addrs[i] != exp_adr) begin
                    errors++;
                    $display("** Error mem_req.adr: got %h, expected %h", rd_addrs[i], exp_adr);
                end
            end
        end
        if (store && write_count - writes0 != 1) begin
            errors++;
            $display("Store to address %h did not give exactly one memory write", a);
        end
    endtask

    always @(negedge clk) begin
        if (cpu_rsp.ack && exp_load) begin
            checks++;
            if (cpu_rsp.dat_r != exp_data) begin
                errors++;
                $display("** Error cpu_rsp.dat_r: got %h, expected %h", cpu_rsp.dat_r, exp_data);
            end
        end
        if (mem_req.stb && mem_rsp.ack && !mem_req.we) begin
            rd_addrs.push_back(mem_req.adr);
        end
        if (mem_req.stb && mem_rsp.ack && mem_req.we) begin
            write_count++;
            checks++;
            if (mem_req.adr != exp_wadr) begin
                errors++;
                $display("** Error mem_req.adr: got %h, expected %h", mem_req.adr, exp_wadr);
            end
            if (mem_req.sel != exp_sel) begin
                errors++;
                $display("** Error mem_req.sel: got %h, expected %h", mem_req.sel, exp_sel);
            end
            if ((mem_req.dat_w & lane_mask) != (exp_wdat & lane_mask)) begin
                errors++;
                $display("** Error mem_req.dat_w: got %h, expected %h",
                         mem_req.dat_w & lane_mask, exp_wdat & lane_mask);
            end
        end
    end

    initial begin
        cache_pkg::lsu_op_e op;
        logic [31:0]        r;
        logic [31:0]        d;
        logic [15:0]        a;
        for (int i = 0; i < 65536; i++) begin
            ref_mem[16'(i)] = 8'(i * 7 + 3) ^ 8'(i >> 8);
        end
        cpu_req = '0;
        reset   = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        run_op(cache_pkg::op_lw, 16'h0108, '0, 8);
        // Word with both positive and negative bytes and halfwords
        for (int o = 0; o < 4; o++) begin
            run_op(cache_pkg::op_lb, 16'h0110 + 16'(o), '0, 0);
            run_op(cache_pkg::op_lbu, 16'h0110 + 16'(o), '0, 0);
            if (o % 2 == 0) begin
                run_op(cache_pkg::op_lh, 16'h0110 + 16'(o), '0, 0);
                run_op(cache_pkg::op_lhu, 16'h0110 + 16'(o), '0, 0);
            end
        end
        run_op(cache_pkg::op_lw, 16'h0110, '0, 0);

        // Store hits, then read the merged words back
        run_op(cache_pkg::op_sb, 16'h0111, 32'h0000_00a5, 0);
        run_op(cache_pkg::op_sh, 16'h0116, 32'h0000_8001, 0);
        run_op(cache_pkg::op_sw, 16'h0118, 32'hdead_beef, 0);
        for (int w = 0; w < 3; w++) begin
            run_op(cache_pkg::op_lw, 16'h0110 + 16'(4 * w), '0, 0);
        end

        // Store miss leaves the line unallocated
        run_op(cache_pkg::op_sw, 16'h0304, 32'h1234_5678, 0);
        run_op(cache_pkg::op_lw, 16'h0304, '0, 8);

        // Same index, different tags
        repeat (3) begin
            run_op(cache_pkg::op_lw, 16'h0500, '0, 8);
            run_op(cache_pkg::op_lhu, 16'h0d06, '0, 8);
        end

        repeat (300) begin
            get_bits(3, r);
            op = cache_pkg::lsu_op_e'({1'b0, r[2:0]});
            get_bits(14, r);
            a = {2'b00, r[13:0]};
            get_bits(32, d);
            if (op inside {cache_pkg::op_lh, cache_pkg::op_lhu, cache_pkg::op_sh}) begin
                a[0] = 1'b0;
            end
            if (op inside {cache_pkg::op_lw, cache_pkg::op_sw}) begin
                a[1:0] = 2'b00;
            end
            run_op(op, a, d, -1);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Generous bound of 200 cycles per transaction
    initial begin
        #(N_TRANS * 200 * 8);
        $display("Watchdog expired before all transactions completed");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- hdl/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl #(
    parameter int LINE_WORDS = 8
) (
    input  logic                            clk,
    input  logic                            reset,
    input  cache_pkg::cpu_req_t             cpu_req,
    output cache_pkg::cpu_rsp_t             cpu_rsp,
    output cache_pkg::wb_req_t              mem_req,
    input  cache_pkg::wb_rsp_t              mem_rsp,
    output logic [cache_pkg::ADDR_W-1:0]    addr,
    input  logic                            hit,
    output logic                            refill_we,
    output logic [$clog2(LINE_WORDS)-1:0]   refill_word,
    output logic [cache_pkg::DATA_W-1:0]    refill_data,
    output logic                            merge_we,
    output logic [3:0]                      merge_sel,
    output logic [cache_pkg::DATA_W-1:0]    merge_data,
    output cache_pkg::lsu_op_e              op,
    input  logic [cache_pkg::DATA_W-1:0]    load_data
);

    localparam int OFF_W = $clog2(LINE_WORDS);

    cache_pkg::cache_state_e      state;
    logic [OFF_W-1:0]             word_cnt;
    logic [cache_pkg::DATA_W-1:0] wdata;
    logic                         ack_q;
    logic [cache_pkg::DATA_W-1:0] rdata_q;
    logic                         accept;
    logic                         last_word;
    logic                         misaligned;

    assign accept = state == cache_pkg::st_idle && cpu_req.cyc && cpu_req.stb && !ack_q;
    assign last_word = word_cnt == OFF_W'(LINE_WORDS - 1);

    assign cpu_rsp.ack   = ack_q;
    assign cpu_rsp.dat_r = rdata_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= cache_pkg::st_idle;
            word_cnt <= '0;
            ack_q    <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            case (state)
                cache_pkg::st_idle: begin
                    if (accept) begin
                        state <= cache_pkg::st_lookup;
                    end
                end
                cache_pkg::st_lookup: begin
                    if (cache_pkg::is_store(op)) begin
                        state <= cache_pkg::st_write;
                    end else if (hit) begin
                        ack_q <= 1'b1;
                        state <= cache_pkg::st_idle;
                    end else begin
                        word_cnt <= '0;
                        state    <= cache_pkg::st_refill;
                    end
                end
                cache_pkg::st_refill: begin
                    if (mem_rsp.ack) begin
                        word_cnt <= word_cnt + 1'b1;
                        // Line complete, the repeated lookup now hits
                        if (last_word) begin
                            state <= cache_pkg::st_lookup;
                        end
                    end
                end
                cache_pkg::st_write: begin
                    if (mem_rsp.ack) begin
                        ack_q <= 1'b1;
                        state <= cache_pkg::st_idle;
                    end
                end
                default: state <= cache_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr  <= cpu_req.adr;
            op    <= cpu_req.op;
            wdata <= cpu_req.dat_w;
        end
        if (state == cache_pkg::st_lookup && hit && !cache_pkg::is_store(op)) begin
            rdata_q <= load_data;
        end
    end

    always_comb begin
        mem_req.cyc   = state == cache_pkg::st_refill || state == cache_pkg::st_write;
        mem_req.stb   = mem_req.cyc;
        mem_req.we    = state == cache_pkg::st_write;
        mem_req.dat_w = cache_pkg::lane_data(op, wdata);
        if (state == cache_pkg::st_write) begin
            mem_req.adr = {addr[cache_pkg::ADDR_W-1:2], 2'b00};
            mem_req.sel = cache_pkg::lane_sel(op, addr[1:0]);
        end else begin
            // Refill walks the line in word order
            mem_req.adr = {addr[cache_pkg::ADDR_W-1:OFF_W+2], word_cnt, 2'b00};
            mem_req.sel = 4'b1111;
        end
    end

    assign refill_we   = state == cache_pkg::st_refill && mem_rsp.ack;
    assign refill_word = word_cnt;
    assign refill_data = mem_rsp.dat_r;

    // Store hits update the line as the write-through completes
    assign merge_we   = state == cache_pkg::st_write && mem_rsp.ack && hit;
    assign merge_sel  = mem_req.sel;
    assign merge_data = mem_req.dat_w;

    always_comb begin
        case (cpu_req.op)
            cache_pkg::op_lh, cache_pkg::op_lhu, cache_pkg::op_sh: misaligned = cpu_req.adr[0];
            cache_pkg::op_lw, cache_pkg::op_sw:                    misaligned = |cpu_req.adr[1:0];
            default:                                               misaligned = 1'b0;
        endcase
    end

    a_aligned: assert property (@(posedge clk) disable iff (reset) accept |-> !misaligned);

    // Wishbone master holds its request until the slave answers
    a_stb_held: assert property (@(posedge clk) disable iff (reset)
        mem_req.stb && !mem_rsp.ack |=> mem_req.stb && $stable(mem_req.adr));

endmodule

//--- hdl/cache_pkg.sv
package cache_pkg;

    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;

    typedef enum logic [3:0] {
        op_lb  = 4'b0000,
        op_lh  = 4'b0001,
        op_lw  = 4'b0010,
        op_lbu = 4'b0011,
        op_lhu = 4'b0100,
        op_sb  = 4'b0101,
        op_sh  = 4'b0110,
        op_sw  = 4'b0111
    } lsu_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_refill,
        st_write
    } cache_state_e;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        lsu_op_e           op;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat_w;
    } cpu_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat_r;
    } cpu_rsp_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [3:0]        sel;
        logic [DATA_W-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat_r;
    } wb_rsp_t;

    function automatic logic is_store(input lsu_op_e op);
        return op == op_sb || op == op_sh || op == op_sw;
    endfunction

    // Loads read the full word
    function automatic logic [3:0] lane_sel(input lsu_op_e op, input logic [1:0] off);
        case (op)
            op_sb:   return 4'b0001 << off;
            op_sh:   return 4'b0011 << {off[1], 1'b0};
            default: return 4'b1111;
        endcase
    endfunction

    // Replicated so every lane the selects can pick holds the data
    function automatic logic [DATA_W-1:0] lane_data(input lsu_op_e op,
                                                     input logic [DATA_W-1:0] d);
        case (op)
            op_sb:   return {4{d[7:0]}};
            op_sh:   return {2{d[15:0]}};
            default: return d;
        endcase
    endfunction

endpackage

//--- hdl/cache_store.sv
`timescale 1ns/1ps

module cache_store #(
    parameter int NUM_LINES  = 64,
    parameter int LINE_WORDS = 8
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cache_pkg::ADDR_W-1:0]    addr,
    output logic                            hit,
    output logic [cache_pkg::DATA_W-1:0]    word,
    input  logic                            refill_we,
    input  logic [$clog2(LINE_WORDS)-1:0]   refill_word,
    input  logic [cache_pkg::DATA_W-1:0]    refill_data,
    input  logic                            merge_we,
    input  logic [3:0]                      merge_sel,
    input  logic [cache_pkg::DATA_W-1:0]    merge_data
);

    localparam int OFF_W = $clog2(LINE_WORDS);
    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int TAG_W = cache_pkg::ADDR_W - IDX_W - OFF_W - 2;

    logic [TAG_W-1:0]             tag_mem  [NUM_LINES];
    logic [cache_pkg::DATA_W-1:0] data_mem [NUM_LINES*LINE_WORDS];
    logic [NUM_LINES-1:0]         valid;

    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] index;
    logic [OFF_W-1:0] offset;
    logic             last_refill;

    assign tag    = addr[cache_pkg::ADDR_W-1 -: TAG_W];
    assign index  = addr[OFF_W+2 +: IDX_W];
    assign offset = addr[2 +: OFF_W];

    assign last_refill = refill_we && refill_word == OFF_W'(LINE_WORDS - 1);

    assign hit  = valid[index] && tag_mem[index] == tag;
    assign word = data_mem[{index, offset}];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (last_refill) begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (last_refill) begin
            tag_mem[index] <= tag;
        end
        if (refill_we) begin
            data_mem[{index, refill_word}] <= refill_data;
        end
        // Byte-wise merge, unselected bytes keep their old value
        if (merge_we) begin
            for (int b = 0; b < 4; b++) begin
                if (merge_sel[b]) begin
                    data_mem[{index, offset}][8*b +: 8] <= merge_data[8*b +: 8];
                end
            end
        end
    end

    a_one_writer: assert property (@(posedge clk) disable iff (reset)
        !(refill_we && merge_we));

endmodule

//--- hdl/cache_top.sv
`timescale 1ns/1ps

module cache_top #(
    parameter int NUM_LINES  = 64,
    parameter int LINE_WORDS = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  cache_pkg::cpu_req_t cpu_req,
    output cache_pkg::cpu_rsp_t cpu_rsp,
    output cache_pkg::wb_req_t  mem_req,
    input  cache_pkg::wb_rsp_t  mem_rsp
);

    localparam int OFF_W = $clog2(LINE_WORDS);

    logic [cache_pkg::ADDR_W-1:0] addr;
    logic                         hit;
    logic [cache_pkg::DATA_W-1:0] word;
    logic                         refill_we;
    logic [OFF_W-1:0]             refill_word;
    logic [cache_pkg::DATA_W-1:0] refill_data;
    logic                         merge_we;
    logic [3:0]                   merge_sel;
    logic [cache_pkg::DATA_W-1:0] merge_data;
    cache_pkg::lsu_op_e           op;
    logic [cache_pkg::DATA_W-1:0] load_data;

    cache_ctrl #(
        .LINE_WORDS (LINE_WORDS)
    ) cache_ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .cpu_req     (cpu_req),
        .cpu_rsp     (cpu_rsp),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .addr        (addr),
        .hit         (hit),
        .refill_we   (refill_we),
        .refill_word (refill_word),
        .refill_data (refill_data),
        .merge_we    (merge_we),
        .merge_sel   (merge_sel),
        .merge_data  (merge_data),
        .op          (op),
        .load_data   (load_data)
    );

    cache_store #(
        .NUM_LINES  (NUM_LINES),
        .LINE_WORDS (LINE_WORDS)
    ) cache_store_i (
        .clk         (clk),
        .reset       (reset),
        .addr        (addr),
        .hit         (hit),
        .word        (word),
        .refill_we   (refill_we),
        .refill_word (refill_word),
        .refill_data (refill_data),
        .merge_we    (merge_we),
        .merge_sel   (merge_sel),
        .merge_data  (merge_data)
    );

    load_align load_align_i (
        .op       (op),
        .byte_off (addr[1:0]),
        .word     (word),
        .data     (load_data)
    );

endmodule

//--- hdl/load_align.sv
`timescale 1ns/1ps

module load_align (
    input  cache_pkg::lsu_op_e           op,
    input  logic [1:0]                   byte_off,
    input  logic [cache_pkg::DATA_W-1:0] word,
    output logic [cache_pkg::DATA_W-1:0] data
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    assign byte_lane = word[8*byte_off +: 8];
    assign half_lane = word[16*byte_off[1] +: 16];

    always_comb begin
        case (op)
            cache_pkg::op_lb:  data = {{24{byte_lane[7]}}, byte_lane};
            cache_pkg::op_lbu: data = {24'b0, byte_lane};
            cache_pkg::op_lh:  data = {{16{half_lane[15]}}, half_lane};
            cache_pkg::op_lhu: data = {16'b0, half_lane};
            // Full word for op_lw
            default:           data = word;
        endcase
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module tb_cache -f cache_sys.f -o tb_cache \
    && ./obj_dir/tb_cache | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }

grep -qx "RESULT: PASS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
